// ==== include/soc_bus_defines.svh ====
`ifndef SOC_BUS_DEFINES_SVH
`define SOC_BUS_DEFINES_SVH

// on-chip data RAM, 32-bit words
`define SOC_RAM_WORDS 1024

// word index width, log2 of SOC_RAM_WORDS
`define SOC_RAM_IDX_W 10

// ram spans 0 .. 4*SOC_RAM_WORDS-1
// everything from here upward goes to the wishbone bridge
`define SOC_WB_BASE 32'h1000_0000

// gap between ram and wishbone space is unmapped
// and reads back as zero

// core reset held this many clk edges after resetn rises
`define SOC_POR_CYCLES 16

`endif

// ==== rtl/soc_bus_pkg.sv ====
`default_nettype none

package soc_bus_pkg;

`include "soc_bus_defines.svh"

   // native bus fields
   typedef logic [31:0] addr_t;     // byte address
   typedef logic [31:0] data_t;
   typedef logic [3:0]  strb_t;     // all zero means read

   // one bit per interrupt line
   typedef logic [31:0] irq_vec_t;

   typedef logic [`SOC_RAM_IDX_W-1:0] ram_idx_t;

   // wishbone bridge states
   typedef enum logic [1:0]
   {
      WB_IDLE,
      WB_BUSY,
      WB_DONE
   } wb_state_e;

endpackage

`default_nettype wire

// ==== rtl/por_reset.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_defines.svh"

module por_reset
(
   input  logic clk,
   input  logic resetn,
   output logic sys_resetn_o
);

   // fills with ones once resetn is released
   logic [`SOC_POR_CYCLES-1:0] rst_chain;

   always_ff @(posedge clk or negedge resetn)
   begin
      if (!resetn)
      begin
         rst_chain <= '0;
      end
      else
      begin
         rst_chain <= {rst_chain[`SOC_POR_CYCLES-2:0], 1'b1};
      end
   end

   assign sys_resetn_o = rst_chain[`SOC_POR_CYCLES-1];   // last stage

endmodule

`default_nettype wire

// ==== rtl/bus_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_defines.svh"

module bus_decode
(
   input  logic                 mem_valid_i,
   input  soc_bus_pkg::addr_t   mem_addr_i,
   output logic                 sel_ram_o,
   output logic                 sel_wb_o,
   output logic                 sel_none_o,
   output soc_bus_pkg::ram_idx_t ram_idx_o
);

   import soc_bus_pkg::*;

   // first byte address past the ram
   localparam addr_t RAM_LIMIT = addr_t'(4 * `SOC_RAM_WORDS);
   localparam addr_t WB_BASE   = `SOC_WB_BASE;

   logic in_ram;
   logic in_wb;

   always_comb
   begin
      in_ram = (mem_addr_i < RAM_LIMIT);
      in_wb  = (mem_addr_i >= WB_BASE);
   end

   // exactly one select while valid, none otherwise
   always_comb
   begin
      sel_ram_o  = 1'b0;
      sel_wb_o   = 1'b0;
      sel_none_o = 1'b0;
      if (mem_valid_i)
      begin
         if (in_ram)
            sel_ram_o = 1'b1;
         else if (in_wb)
            sel_wb_o = 1'b1;
         else
            sel_none_o = 1'b1;   // hole between ram and wishbone
      end
   end

   // drop byte offset
   assign ram_idx_o = mem_addr_i[`SOC_RAM_IDX_W+1:2];

endmodule

`default_nettype wire

// ==== rtl/data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_defines.svh"

module data_ram
(
   input  logic                  clk,
   input  logic                  resetn,
   input  logic                  sel_i,
   input  soc_bus_pkg::ram_idx_t idx_i,
   input  soc_bus_pkg::data_t    wdata_i,
   input  soc_bus_pkg::strb_t    wstrb_i,
   output logic                  ready_o,
   output soc_bus_pkg::data_t    rdata_o
);

   import soc_bus_pkg::*;

   data_t mem [`SOC_RAM_WORDS];
   logic  accept;

   // no new access in the cycle we are answering
   assign accept = sel_i && !ready_o;

   always_ff @(posedge clk or negedge resetn)
   begin
      if (!resetn)
         ready_o <= 1'b0;
      else
         ready_o <= accept;
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         rdata_o <= mem[idx_i];   // old word, only used on reads
         for (int b = 0; b < 4; b++)
         begin
            if (wstrb_i[b])
               mem[idx_i][8*b +: 8] <= wdata_i[8*b +: 8];
         end
      end
   end

endmodule

`default_nettype wire

// ==== rtl/wb_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_bridge
(
   input  logic               clk,
   input  logic               resetn,
   input  logic               sel_i,
   input  soc_bus_pkg::addr_t addr_i,
   input  soc_bus_pkg::data_t wdata_i,
   input  soc_bus_pkg::strb_t wstrb_i,
   output logic               ready_o,
   output soc_bus_pkg::data_t rdata_o,
   output logic               wb_cyc_o,
   output logic               wb_stb_o,
   output logic               wb_we_o,
   output soc_bus_pkg::addr_t wb_adr_o,
   output soc_bus_pkg::data_t wb_dat_o,
   output soc_bus_pkg::strb_t wb_sel_o,
   input  logic               wb_ack_i,
   input  soc_bus_pkg::data_t wb_dat_i
);

   import soc_bus_pkg::*;

   wb_state_e state_q;
   logic      start;
   logic      acked;

   assign start = (state_q == WB_IDLE) && sel_i;
   assign acked = (state_q == WB_BUSY) && wb_ack_i;

   always_ff @(posedge clk or negedge resetn)
   begin
      if (!resetn)
      begin
         state_q <= WB_IDLE;
      end
      else
      begin
         case (state_q)
            WB_IDLE: if (start) state_q <= WB_BUSY;
            WB_BUSY: if (acked) state_q <= WB_DONE;
            WB_DONE: state_q <= WB_IDLE;   // one cycle of ready
            default: state_q <= WB_IDLE;
         endcase
      end
   end

   // request latched once, held for the whole cycle
   always_ff @(posedge clk)
   begin
      if (start)
      begin
         wb_adr_o <= addr_i;
         wb_dat_o <= wdata_i;
         wb_we_o  <= |wstrb_i;
         wb_sel_o <= (|wstrb_i) ? wstrb_i : 4'hf;   // reads fetch whole word
      end
      if (acked)
         rdata_o <= wb_dat_i;
   end

   assign wb_cyc_o = (state_q == WB_BUSY);
   assign wb_stb_o = (state_q == WB_BUSY);
   assign ready_o  = (state_q == WB_DONE);

endmodule

`default_nettype wire

// ==== rtl/irq_edge.sv ====
`timescale 1ns/1ps
`default_nettype none

module irq_edge
(
   input  logic                  clk,
   input  logic                  resetn,
   input  soc_bus_pkg::irq_vec_t irq_i,
   input  soc_bus_pkg::irq_vec_t irq_mask_i,
   output soc_bus_pkg::irq_vec_t irq_o
);

   import soc_bus_pkg::*;

   irq_vec_t irq_s1;
   irq_vec_t irq_s2;
   irq_vec_t irq_s3;   // history for edge detect

   always_ff @(posedge clk or negedge resetn)
   begin
      if (!resetn)
      begin
         irq_s1 <= '0;
         irq_s2 <= '0;
         irq_s3 <= '0;
      end
      else
      begin
         irq_s1 <= irq_i & ~irq_mask_i;   // set mask bit blocks line
         irq_s2 <= irq_s1;
         irq_s3 <= irq_s2;
      end
   end

   // rising edge only, one cycle per edge
   assign irq_o = irq_s2 & ~irq_s3;

endmodule

`default_nettype wire

// ==== rtl/rsp_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module rsp_merge
(
   input  logic               clk,
   input  logic               resetn,
   input  logic               sel_none_i,
   input  logic               ram_ready_i,
   input  logic               wb_ready_i,
   input  soc_bus_pkg::data_t ram_rdata_i,
   input  soc_bus_pkg::data_t wb_rdata_i,
   output logic               mem_ready_o,
   output soc_bus_pkg::data_t mem_rdata_o
);

   import soc_bus_pkg::*;

   logic none_pend;   // reply for unmapped access

   // same one-cycle timing as the ram
   always_ff @(posedge clk or negedge resetn)
   begin
      if (!resetn)
         none_pend <= 1'b0;
      else
         none_pend <= sel_none_i && !none_pend;
   end

   assign mem_ready_o = none_pend | ram_ready_i | wb_ready_i;

   // unmapped reads and idle cycles give zero
   always_comb
   begin
      if (ram_ready_i)
         mem_rdata_o = ram_rdata_i;
      else if (wb_ready_i)
         mem_rdata_o = wb_rdata_i;
      else
         mem_rdata_o = data_t'(0);
   end

endmodule

`default_nettype wire

// ==== rtl/soc_bus_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_bus_top
(
   input  logic                  clk,
   input  logic                  resetn,
   output logic                  sys_resetn_o,
   // native bus from the core
   input  logic                  mem_valid_i,
   input  soc_bus_pkg::addr_t    mem_addr_i,
   input  soc_bus_pkg::data_t    mem_wdata_i,
   input  soc_bus_pkg::strb_t    mem_wstrb_i,
   output logic                  mem_ready_o,
   output soc_bus_pkg::data_t    mem_rdata_o,
   // external wishbone slave
   output logic                  wb_cyc_o,
   output logic                  wb_stb_o,
   output logic                  wb_we_o,
   output soc_bus_pkg::addr_t    wb_adr_o,
   output soc_bus_pkg::data_t    wb_dat_o,
   output soc_bus_pkg::strb_t    wb_sel_o,
   input  logic                  wb_ack_i,
   input  soc_bus_pkg::data_t    wb_dat_i,
   // interrupts
   input  soc_bus_pkg::irq_vec_t irq_i,
   input  soc_bus_pkg::irq_vec_t irq_mask_i,
   output soc_bus_pkg::irq_vec_t irq_o
);

   import soc_bus_pkg::*;

   logic     sel_ram;
   logic     sel_wb;
   logic     sel_none;
   ram_idx_t ram_idx;
   logic     ram_ready;
   data_t    ram_rdata;
   logic     wb_ready;
   data_t    wb_rdata;

   // stretched reset, used by everything below
   por_reset u_por (
      .clk          (clk),
      .resetn       (resetn),
      .sys_resetn_o (sys_resetn_o)
   );

   bus_decode u_decode (
      .mem_valid_i (mem_valid_i),
      .mem_addr_i  (mem_addr_i),
      .sel_ram_o   (sel_ram),
      .sel_wb_o    (sel_wb),
      .sel_none_o  (sel_none),
      .ram_idx_o   (ram_idx)
   );

   data_ram u_ram (
      .clk     (clk),
      .resetn  (sys_resetn_o),
      .sel_i   (sel_ram),
      .idx_i   (ram_idx),
      .wdata_i (mem_wdata_i),
      .wstrb_i (mem_wstrb_i),
      .ready_o (ram_ready),
      .rdata_o (ram_rdata)
   );

   wb_bridge u_wb (
      .clk      (clk),
      .resetn   (sys_resetn_o),
      .sel_i    (sel_wb),
      .addr_i   (mem_addr_i),
      .wdata_i  (mem_wdata_i),
      .wstrb_i  (mem_wstrb_i),
      .ready_o  (wb_ready),
      .rdata_o  (wb_rdata),
      .wb_cyc_o (wb_cyc_o),
      .wb_stb_o (wb_stb_o),
      .wb_we_o  (wb_we_o),
      .wb_adr_o (wb_adr_o),
      .wb_dat_o (wb_dat_o),
      .wb_sel_o (wb_sel_o),
      .wb_ack_i (wb_ack_i),
      .wb_dat_i (wb_dat_i)
   );

   irq_edge u_irq (
      .clk        (clk),
      .resetn     (sys_resetn_o),
      .irq_i      (irq_i),
      .irq_mask_i (irq_mask_i),
      .irq_o      (irq_o)
   );

   rsp_merge u_merge (
      .clk         (clk),
      .resetn      (sys_resetn_o),
      .sel_none_i  (sel_none),
      .ram_ready_i (ram_ready),
      .wb_ready_i  (wb_ready),
      .ram_rdata_i (ram_rdata),
      .wb_rdata_i  (wb_rdata),
      .mem_ready_o (mem_ready_o),
      .mem_rdata_o (mem_rdata_o)
   );

endmodule

`default_nettype wire

// ==== tb/tb_clkgen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen
#(
   parameter int HALF_NS = 4   // 8 ns period
)
(
   output logic clk_o
);

   initial
   begin
      clk_o = 1'b0;
      forever
         #(HALF_NS) clk_o = ~clk_o;
   end

endmodule

`default_nettype wire

// ==== tb/tb_soc_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_defines.svh"

module tb_soc_bus;

   import soc_bus_pkg::*;

   localparam int WAIT_LIMIT = 40;

   logic     clk, resetn, sys_resetn_o;
   logic     mem_valid_i, mem_ready_o;
   addr_t    mem_addr_i;
   data_t    mem_wdata_i, mem_rdata_o;
   strb_t    mem_wstrb_i;
   logic     wb_cyc_o, wb_stb_o, wb_we_o, wb_ack_i;
   addr_t    wb_adr_o;
   data_t    wb_dat_o, wb_dat_i;
   strb_t    wb_sel_o;
   irq_vec_t irq_i, irq_mask_i, irq_o;

   int       errors;
   int       timeouts;
   addr_t    req_addr;
   data_t    req_wdata;
   strb_t    req_strb;
   logic     req_wb;      // a wishbone access is in flight
   logic     ack_prev;
   int       ack_wait;
   irq_vec_t irq_h1, irq_h2, irq_h3;   // masked input history
   data_t    ram_ref [`SOC_RAM_WORDS];
   int       ram_used [$];
   data_t    wb_mem [addr_t];

   tb_clkgen u_clkgen (.clk_o(clk));

   soc_bus_top u_soc_bus_top (.*);

   // cyc and stb always move together
   assert property (@(posedge clk) disable iff (!resetn) wb_cyc_o == wb_stb_o)
   else
   begin
      errors++;
      $display("ERROR wb stb: expected %b, actual %b", wb_cyc_o, wb_stb_o);
   end

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (act === exp)
      else
      begin
         errors++;
         $display("ERROR %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   function automatic data_t merge_bytes(data_t old_w, data_t new_w, strb_t strb);
      data_t res;
      res = old_w;
      for (int b = 0; b < 4; b++)
      begin
         if (strb[b])
            res[8*b +: 8] = new_w[8*b +: 8];
      end
      return res;
   endfunction

   // never written words read back as their own address
   function automatic data_t wb_word(addr_t a);
      return wb_mem.exists(a) ? wb_mem[a] : a;
   endfunction

   // one native access starting and ending 1 ns past a rising edge
   task automatic bus_access(input string name, input addr_t addr, input data_t wdata,
                             input strb_t strb, input int exp_lat, output data_t rdata);
      int n;
      req_addr    = addr;
      req_wdata   = wdata;
      req_strb    = strb;
      req_wb      = (addr >= `SOC_WB_BASE);
      mem_addr_i  = addr;
      mem_wdata_i = wdata;
      mem_wstrb_i = strb;
      mem_valid_i = 1'b1;
      n = 0;
      do
      begin
         @(negedge clk);
         n++;
      end
      while (!mem_ready_o && n < WAIT_LIMIT);
      if (!mem_ready_o)
      begin
         timeouts++;
         $display("no ready within %0d cycles for %s access at %h", WAIT_LIMIT, name, addr);
      end
      else if (exp_lat > 0)
         check_value({name, " latency"}, exp_lat, n);
      rdata = mem_rdata_o;
      @(posedge clk);
      #1;
      mem_valid_i = 1'b0;
      mem_wstrb_i = 4'h0;
      req_wb      = 1'b0;
      @(posedge clk);   // idle cycle where ready must stay low
      #1;
   endtask

   // wishbone slave with random 0 to 5 cycle ack delay
   always @(negedge clk)
   begin
      if (wb_ack_i)
      begin
         @(posedge clk);
         #1;
         wb_ack_i = 1'b0;
         ack_wait = -1;
      end
      else if (wb_cyc_o)
      begin
         if (ack_wait < 0)
            ack_wait = $urandom_range(5, 0);
         if (ack_wait > 0)
            ack_wait--;
         else
         begin
            @(posedge clk);
            #1;
            if (wb_we_o)
               wb_mem[wb_adr_o] = merge_bytes(wb_word(wb_adr_o), wb_dat_o, wb_sel_o);
            wb_dat_i = wb_word(wb_adr_o);
            wb_ack_i = 1'b1;
         end
      end
   end

   always @(negedge clk)
   begin
      if (!sys_resetn_o)
      begin
         check_value("reset outputs", 0, {mem_ready_o, wb_cyc_o, wb_stb_o});
         check_value("reset irq", 0, irq_o);
         irq_h1 = '0;
         irq_h2 = '0;
         irq_h3 = '0;
      end
      else
      begin
         // high two samples back and low three samples back
         check_value("irq pulse", irq_h2 & ~irq_h3, irq_o);
         irq_h3 = irq_h2;
         irq_h2 = irq_h1;
         irq_h1 = irq_i & ~irq_mask_i;
      end
      if (wb_cyc_o)
      begin
         check_value("wb adr", req_addr, wb_adr_o);
         check_value("wb we", |req_strb, wb_we_o);
         check_value("wb sel", (|req_strb) ? req_strb : 4'hf, wb_sel_o);
         if (|req_strb)
            check_value("wb dat", req_wdata, wb_dat_o);
      end
      if (req_wb)
         check_value("wb ready after ack", ack_prev, mem_ready_o);
      else
         check_value("wb cycle", 0, wb_cyc_o);
      if (ack_prev)
         check_value("wb cyc after ack", 0, wb_cyc_o);
      if (!mem_valid_i)
         check_value("idle ready", 0, mem_ready_o);
      ack_prev = wb_ack_i;
   end

   initial
   begin
      data_t rd;
      data_t d;
      data_t ref_val;
      strb_t s;
      addr_t a;
      int    idx;
      errors      = 0;
      timeouts    = 0;
      resetn      = 1'b0;
      mem_valid_i = 1'b0;
      mem_addr_i  = '0;
      mem_wdata_i = '0;
      mem_wstrb_i = '0;
      wb_ack_i    = 1'b0;
      wb_dat_i    = '0;
      irq_i       = '0;
      irq_mask_i  = '0;
      req_wb      = 1'b0;
      req_strb    = '0;
      ack_prev    = 1'b0;
      ack_wait    = -1;
      void'($urandom(32'h53dd));
      repeat (5) @(posedge clk);
      #1;
      resetn = 1'b1;
      for (int k = 0; k < `SOC_POR_CYCLES + 4; k++)
      begin
         @(negedge clk);
         check_value("por release", k >= `SOC_POR_CYCLES, sys_resetn_o);
      end
      @(posedge clk);
      #1;
      for (int i = 0; i < 16; i++)
      begin
         idx = $urandom_range(`SOC_RAM_WORDS - 1, 0);
         d = $urandom;
         bus_access("ram fill", addr_t'(idx * 4), d, 4'hf, 2, rd);
         ram_ref[idx] = d;
         ram_used.push_back(idx);
      end
      for (int i = 0; i < 48; i++)
      begin
         idx = ram_used[$urandom_range(ram_used.size() - 1, 0)];
         d = $urandom;
         s = (i % 2) ? strb_t'($urandom_range(15, 1)) : 4'h0;
         bus_access("ram", addr_t'(idx * 4), d, s, 2, rd);
         if (s == 4'h0)
            check_value("ram read", ram_ref[idx], rd);
         else
            ram_ref[idx] = merge_bytes(ram_ref[idx], d, s);
      end
      for (int i = 0; i < 40; i++)
      begin
         a = `SOC_WB_BASE + addr_t'($urandom_range(31, 0) * 4);   // small window so words repeat
         d = $urandom;
         s = $urandom_range(1, 0) ? strb_t'($urandom_range(15, 1)) : 4'h0;
         ref_val = wb_word(a);
         bus_access("wb", a, d, s, 0, rd);
         if (s == 4'h0)
            check_value("wb read", ref_val, rd);
      end
      for (int i = 0; i < 8; i++)
      begin
         idx = ram_used[$urandom_range(ram_used.size() - 1, 0)];
         a = (i == 0) ? addr_t'(4 * `SOC_RAM_WORDS) : (32'h0200_0000 | addr_t'(idx * 4));
         s = (i % 2) ? 4'hf : 4'h0;
         bus_access("unmapped", a, $urandom, s, 2, rd);
         if (s == 4'h0)
            check_value("unmapped read", 0, rd);
      end
      // unmapped writes above alias these ram indices
      foreach (ram_used[j])
      begin
         bus_access("ram readback", addr_t'(ram_used[j] * 4), 0, 4'h0, 2, rd);
         check_value("ram readback", ram_ref[ram_used[j]], rd);
      end
      irq_mask_i = $urandom;
      for (int i = 0; i < 64; i++)
      begin
         @(posedge clk);
         #1;
         irq_i = irq_i ^ ($urandom & $urandom);   // sparse toggles so most lines hold
         if (i == 32)
            irq_mask_i = $urandom;
      end
      repeat (4) @(posedge clk);
      $display("errors: %0d, timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+include
rtl/soc_bus_pkg.sv
rtl/por_reset.sv
rtl/bus_decode.sv
rtl/data_ram.sv
rtl/wb_bridge.sv
rtl/irq_edge.sv
rtl/rsp_merge.sv
rtl/soc_bus_top.sv
tb/tb_clkgen.sv
tb/tb_soc_bus.sv

// ==== Bender.yml ====
package:
  name: soc_bus

sources:
  - include_dirs:
      - include
    files:
      - rtl/soc_bus_pkg.sv
      - rtl/por_reset.sv
      - rtl/bus_decode.sv
      - rtl/data_ram.sv
      - rtl/wb_bridge.sv
      - rtl/irq_edge.sv
      - rtl/rsp_merge.sv
      - rtl/soc_bus_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_clkgen.sv
      - tb/tb_soc_bus.sv
